// ==== common/seq_pkg.sv ====
/*
 * Shared widths and packed structs for the decode sequence-number block
 * Sequence number, age parity, allocation, retire and squash records
 */

package seq_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  // Inter part counts squash epochs
  // Both widths must be above 1, only half of each space is live
  localparam int SEQ_INTER_BITS = 2;

  // Intra part counts instructions within an epoch
  // Kept small so a wrap is easy to reach
  localparam int SEQ_INTRA_BITS = 4;

  // Full sequence number width
  localparam int SEQ_BITS = SEQ_INTER_BITS + SEQ_INTRA_BITS;

  // ----------------------------------------------------------------------
  // Records
  // ----------------------------------------------------------------------

  // Sequence number, inter in the upper bits
  typedef struct packed {
    logic [SEQ_INTER_BITS-1:0] inter;
    logic [SEQ_INTRA_BITS-1:0] intra;
  } seq_num_t;

  // Age parity per part
  // A 1 means values with MSB set are the older ones
  typedef struct packed {
    logic inter;
    logic intra;
  } age_parity_t;

  // Allocation result toward decode
  typedef struct packed {
    logic     grant;
    seq_num_t seq;
  } alloc_t;

  // Retire result, also the commit into the generator
  typedef struct packed {
    logic     valid;
    seq_num_t seq;
  } retire_t;

  // Squash request, seq is the squashing instruction
  typedef struct packed {
    logic     valid;
    seq_num_t seq;
  } squash_t;

endpackage

// ==== seq_alloc/seq_age_cmp.sv ====
/*
 * Age comparator for two sequence numbers
 * older_eq is high when a is older than or equal to b
 */
`timescale 1ns/1ps

module seq_age_cmp (
  input  seq_pkg::seq_num_t    a,
  input  seq_pkg::seq_num_t    b,
  input  seq_pkg::age_parity_t parity,
  output logic                 older_eq
);

  logic inter_lt;
  logic inter_eq;
  logic intra_le;

  // Inter part decides unless both epochs match
  // Signed compare puts MSB-set values first
  assign inter_lt = parity.inter ?
                    ($signed(a.inter) < $signed(b.inter)) :
                    (a.inter < b.inter);

  assign inter_eq = (a.inter == b.inter);

  // Same epoch, fall back to instruction order
  assign intra_le = parity.intra ?
                    ($signed(a.intra) <= $signed(b.intra)) :
                    (a.intra <= b.intra);

  assign older_eq = inter_lt || (inter_eq && intra_le);

endmodule

// ==== seq_alloc/seq_num_gen.sv ====
/*
 * Sequence number generator
 * Hands out inter/intra numbers, follows commit and squash,
 * stalls when a new number would overlap live numbers
 */
`timescale 1ns/1ps

module seq_num_gen (
  input  logic                 clk,
  input  logic                 rst,

  // ----------------------------------------------------------------------
  // Allocation
  // ----------------------------------------------------------------------
  input  logic                 seq_num_alloc,
  output seq_pkg::seq_num_t    next_seq,
  output logic                 next_seq_val,

  // ----------------------------------------------------------------------
  // Commit, squash and age parity
  // ----------------------------------------------------------------------
  input  seq_pkg::retire_t     commit,
  input  seq_pkg::squash_t     squash,
  output seq_pkg::age_parity_t parity
);

  localparam int INTER_W = seq_pkg::SEQ_INTER_BITS;
  localparam int INTRA_W = seq_pkg::SEQ_INTRA_BITS;

  // ----------------------------------------------------------------------
  // Intra part
  // ----------------------------------------------------------------------

  // Next number to hand out and next number expected to commit
  logic [INTRA_W-1:0] curr_intra;
  logic [INTRA_W-1:0] commit_intra;
  logic               intra_ok;
  logic               inter_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      curr_intra <= '0;
    end else if (squash.valid) begin
      // New epoch restarts instruction numbering
      curr_intra <= '0;
    end else if (seq_num_alloc && intra_ok) begin
      curr_intra <= curr_intra + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_intra <= '0;
    end else if (squash.valid) begin
      commit_intra <= '0;
    end else if (commit.valid) begin
      commit_intra <= commit.seq.intra + 1'b1;
    end
  end

  // Stall at the end of a half while the other half still waits on commit
  always_comb begin
    intra_ok = inter_ok;
    if ((&curr_intra[INTRA_W-2:0]) &&
        (curr_intra[INTRA_W-1] != commit_intra[INTRA_W-1])) begin
      intra_ok = 1'b0;
    end
  end

  assign parity.intra = commit_intra[INTRA_W-1];

  // ----------------------------------------------------------------------
  // Inter part
  // ----------------------------------------------------------------------

  logic [INTER_W-1:0] curr_inter;
  logic [INTER_W-1:0] commit_inter;
  logic               squash_older_eq;
  logic               commit_older;

  // Signed view when MSB-set epochs are the older ones
  always_comb begin
    if (parity.inter) begin
      squash_older_eq = $signed(curr_inter) <= $signed(squash.seq.inter);
      commit_older    = $signed(commit_inter) < $signed(commit.seq.inter);
    end else begin
      squash_older_eq = curr_inter <= squash.seq.inter;
      commit_older    = commit_inter < commit.seq.inter;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      curr_inter <= '0;
    end else if (squash.valid && squash_older_eq) begin
      // Survivors keep the squash epoch, new work starts one past it
      curr_inter <= squash.seq.inter + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_inter <= '0;
    end else if (commit.valid && commit_older) begin
      commit_inter <= commit.seq.inter + 1'b1;
    end
  end

  // Epoch would collide with epochs not yet committed
  always_comb begin
    inter_ok = 1'b1;
    if (!(|curr_inter[INTER_W-2:0]) &&
        (curr_inter[INTER_W-1] != commit_inter[INTER_W-1])) begin
      inter_ok = 1'b0;
    end
  end

  assign parity.inter = commit_inter[INTER_W-1];

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------

  assign next_seq.inter = curr_inter;
  assign next_seq.intra = curr_intra;
  assign next_seq_val   = intra_ok;

endmodule

// ==== hdl/inflight_table.sv ====
/*
 * In-flight table of granted sequence numbers in program order
 * Ring buffer with head pop on retire and tail truncation on squash
 */
`timescale 1ns/1ps

module inflight_table #(
  parameter int DEPTH = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       seq_num_alloc,
  input  seq_pkg::seq_num_t          alloc_seq,
  input  logic                       retire_req,
  input  seq_pkg::squash_t           squash,
  input  seq_pkg::age_parity_t       parity,
  output seq_pkg::retire_t           retire,
  output logic                       full,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  seq_pkg::seq_num_t entry [DEPTH];
  logic [PTR_W-1:0]  head;
  logic [PTR_W-1:0]  tail;
  logic [DEPTH-1:0]  keep;
  logic [CNT_W-1:0]  keep_count;
  logic [PTR_W-1:0]  keep_tail;
  logic              push;
  logic              pop;

  // Ring pointer advance with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] p,
                                               input logic [CNT_W-1:0] n);
    logic [CNT_W:0] sum;
    sum = p + n;
    if (sum >= DEPTH) begin
      sum = sum - (CNT_W+1)'(DEPTH);
    end
    return sum[PTR_W-1:0];
  endfunction

  // ----------------------------------------------------------------------
  // Squash truncation
  // ----------------------------------------------------------------------

  // One comparator per slot, against the squashing number
  for (genvar k = 0; k < DEPTH; k++) begin : g_cmp
    seq_age_cmp u_seq_age_cmp (
      .a        (entry[k]),
      .b        (squash.seq),
      .parity   (parity),
      .older_eq (keep[k])
    );
  end

  // Count the unbroken run of survivors from the head
  always_comb begin
    logic             run;
    logic [PTR_W-1:0] idx;
    run        = 1'b1;
    idx        = head;
    keep_count = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (run && (CNT_W'(i) < count) && keep[idx]) begin
        keep_count = keep_count + 1'b1;
      end else begin
        run = 1'b0;
      end
      idx = ptr_add(idx, CNT_W'(1));
    end
  end

  assign keep_tail = ptr_add(head, keep_count);

  // ----------------------------------------------------------------------
  // Push, pop and pointers
  // ----------------------------------------------------------------------

  assign full = (count == CNT_W'(DEPTH));
  assign push = seq_num_alloc && !full && !squash.valid;
  assign pop  = retire_req && (count != '0) && !squash.valid;

  // Oldest entry goes out in the request cycle
  assign retire.valid = pop;
  assign retire.seq   = entry[head];

  always_ff @(posedge clk) begin
    if (push) begin
      entry[tail] <= alloc_seq;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (squash.valid) begin
      // Drop everything younger than the squashing instruction
      tail  <= keep_tail;
      count <= keep_count;
    end else begin
      if (pop) begin
        head <= ptr_add(head, CNT_W'(1));
      end
      if (push) begin
        tail <= ptr_add(tail, CNT_W'(1));
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hdl/squash_recovery_fsm.sv ====
/*
 * Squash recovery state machine
 * Blocks allocation for RECOVERY_CYCLES cycles after each squash
 */
`timescale 1ns/1ps

module squash_recovery_fsm #(
  parameter int RECOVERY_CYCLES = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic squash_valid,
  output logic recovering
);

  localparam int CNT_W = $clog2(RECOVERY_CYCLES + 1);

  typedef enum logic {
    RUN,
    RECOVER
  } state_t;

  state_t           state;
  state_t           state_next;
  logic [CNT_W-1:0] cnt;

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      RUN: begin
        if (squash_valid) begin
          state_next = RECOVER;
        end
      end
      RECOVER: begin
        // Stay while reloaded or still counting down
        if (!squash_valid && (cnt == '0)) begin
          state_next = RUN;
        end
      end
      default: state_next = RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RUN;
    end else begin
      state <= state_next;
    end
  end

  // Load on every squash, last blocked cycle sees zero
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (squash_valid) begin
      cnt <= CNT_W'(RECOVERY_CYCLES - 1);
    end else if (state == RECOVER && cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign recovering = (state == RECOVER);

endmodule

// ==== hdl/decode_seq_top.sv ====
/*
 * Decode sequence-number block top level
 * Generator, in-flight table and squash recovery with grant priorities
 */
`timescale 1ns/1ps

module decode_seq_top #(
  parameter int DEPTH           = 8,
  parameter int RECOVERY_CYCLES = 3
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       alloc_req,
  input  logic                       retire_req,
  input  seq_pkg::squash_t           squash,
  output seq_pkg::alloc_t            alloc,
  output seq_pkg::retire_t           retire,
  output logic [$clog2(DEPTH+1)-1:0] inflight_count
);

  seq_pkg::seq_num_t    next_seq;
  seq_pkg::age_parity_t parity;
  logic                 next_seq_val;
  logic                 recovering;
  logic                 table_full;
  logic                 grant;
  logic                 retire_req_ok;

  // ----------------------------------------------------------------------
  // Priorities
  // ----------------------------------------------------------------------

  // Squash wins over both grant and retire in its cycle
  assign grant = alloc_req && next_seq_val && !recovering && !table_full &&
                 !squash.valid;
  assign retire_req_ok = retire_req && !squash.valid;

  assign alloc.grant = grant;
  assign alloc.seq   = next_seq;

  // ----------------------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------------------

  seq_num_gen u_seq_num_gen (
    .clk           (clk),
    .rst           (rst),
    .seq_num_alloc (grant),
    .next_seq      (next_seq),
    .next_seq_val  (next_seq_val),
    .commit        (retire),
    .squash        (squash),
    .parity        (parity)
  );

  inflight_table #(
    .DEPTH (DEPTH)
  ) u_inflight_table (
    .clk           (clk),
    .rst           (rst),
    .seq_num_alloc (grant),
    .alloc_seq     (next_seq),
    .retire_req    (retire_req_ok),
    .squash        (squash),
    .parity        (parity),
    .retire        (retire),
    .full          (table_full),
    .count         (inflight_count)
  );

  squash_recovery_fsm #(
    .RECOVERY_CYCLES (RECOVERY_CYCLES)
  ) u_squash_recovery_fsm (
    .clk          (clk),
    .rst          (rst),
    .squash_valid (squash.valid),
    .recovering   (recovering)
  );

endmodule

// ==== verif/seq_checker.sv ====
/*
 * Testbench checker for the decode sequence-number block
 * Compares DUT outputs with the expected row, scoreboard of retire order
 */
`timescale 1ns/1ps

module seq_checker (
  input  logic             clk,
  input  logic             active,
  input  seq_pkg::squash_t squash,
  input  seq_pkg::alloc_t  alloc,
  input  seq_pkg::retire_t retire,
  input  logic [3:0]       inflight_count,
  input  seq_pkg::alloc_t  exp_alloc,
  input  seq_pkg::retire_t exp_retire,
  input  logic [3:0]       exp_count,
  output int               error_count
);

  // Granted numbers still in flight, oldest at the front
  seq_pkg::seq_num_t granted [$];
  int                errors = 0;

  assign error_count = errors;

  task automatic compare(input string name, input int exp_val, input int act_val);
    if (exp_val != act_val) begin
      $display("FAILED t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp_val, act_val);
      errors++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Program order scoreboard
  // ----------------------------------------------------------------------

  task automatic track_order();
    if (retire.valid) begin
      if (granted.size() == 0) begin
        $display("t=%0t retire of 0x%0h with no granted number outstanding",
                 $time, retire.seq);
        errors++;
      end else begin
        if (granted[0] != retire.seq) begin
          $display("t=%0t retired number 0x%0h is not the oldest granted number 0x%0h",
                   $time, retire.seq, granted[0]);
          errors++;
        end
        void'(granted.pop_front());
      end
    end
    if (alloc.grant) begin
      granted.push_back(alloc.seq);
    end
    // Squash keeps everything up to the squashing number
    if (squash.valid) begin
      while (granted.size() > 0 && granted[$] != squash.seq) begin
        void'(granted.pop_back());
      end
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (active) begin
      compare("alloc.grant", int'(exp_alloc.grant), int'(alloc.grant));
      if (exp_alloc.grant) begin
        compare("alloc.seq", int'(exp_alloc.seq), int'(alloc.seq));
      end
      compare("retire.valid", int'(exp_retire.valid), int'(retire.valid));
      if (exp_retire.valid) begin
        compare("retire.seq", int'(exp_retire.seq), int'(retire.seq));
      end
      compare("inflight_count", int'(exp_count), int'(inflight_count));
      track_order();
    end
  end

endmodule

// ==== verif/tb_decode_seq.sv ====
/*
 * Testbench top for the decode sequence-number block
 * Clock, reset, stimulus table, driving loop, watchdog and closing report
 */
`timescale 1ns/1ps

module tb_decode_seq;

  // One stimulus row, inputs first, then the expected outputs
  typedef struct packed {
    logic             alloc_req;
    logic             retire_req;
    seq_pkg::squash_t squash;
    seq_pkg::alloc_t  exp_alloc;
    seq_pkg::retire_t exp_retire;
    logic [3:0]       exp_count;
  } row_t;

  logic             clk = 1'b0;
  logic             rst;
  logic             active;
  logic             table_ready = 1'b0;
  int               watchdog_ns;
  int               errors;
  row_t             cur;
  row_t             rows [$];
  logic             alloc_req;
  logic             retire_req;
  seq_pkg::squash_t squash;
  seq_pkg::alloc_t  alloc;
  seq_pkg::retire_t retire;
  logic [3:0]       inflight_count;

  always #10 clk = ~clk;

  assign alloc_req  = cur.alloc_req;
  assign retire_req = cur.retire_req;
  assign squash     = cur.squash;

  decode_seq_top #(
    .DEPTH           (8),
    .RECOVERY_CYCLES (3)
  ) u_decode_seq_top (
    .clk            (clk),
    .rst            (rst),
    .alloc_req      (alloc_req),
    .retire_req     (retire_req),
    .squash         (squash),
    .alloc          (alloc),
    .retire         (retire),
    .inflight_count (inflight_count)
  );

  seq_checker u_seq_checker (
    .clk            (clk),
    .active         (active),
    .squash         (squash),
    .alloc          (alloc),
    .retire         (retire),
    .inflight_count (inflight_count),
    .exp_alloc      (cur.exp_alloc),
    .exp_retire     (cur.exp_retire),
    .exp_count      (cur.exp_count),
    .error_count    (errors)
  );

  task automatic add_row(input logic a, input logic r, input logic sq, input logic [5:0] sq_seq,
                         input logic g, input logic [5:0] g_seq, input logic rv,
                         input logic [5:0] r_seq, input logic [3:0] cnt);
    row_t row;
    row.alloc_req        = a;
    row.retire_req       = r;
    row.squash.valid     = sq;
    row.squash.seq       = sq_seq;
    row.exp_alloc.grant  = g;
    row.exp_alloc.seq    = g_seq;
    row.exp_retire.valid = rv;
    row.exp_retire.seq   = r_seq;
    row.exp_count        = cnt;
    rows.push_back(row);
  endtask

  // ----------------------------------------------------------------------
  // Columns: alloc_req retire_req squash seq | grant seq retire seq count
  // ----------------------------------------------------------------------
  task automatic build_table();
    // Empty retire ignored, grants count up from 0
    add_row(1'b0, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 6'h00, 4'd0);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h00, 1'b0, 6'h00, 4'd0);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h01, 1'b0, 6'h00, 4'd1);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h02, 1'b0, 6'h00, 4'd2);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b1, 6'h03, 1'b1, 6'h00, 4'd3);
    add_row(1'b0, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b1, 6'h01, 4'd3);
    // Fill to 8 entries, then grant held off until a retire
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h04, 1'b0, 6'h00, 4'd2);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h05, 1'b0, 6'h00, 4'd3);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h06, 1'b0, 6'h00, 4'd4);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h07, 1'b0, 6'h00, 4'd5);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h08, 1'b0, 6'h00, 4'd6);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h09, 1'b0, 6'h00, 4'd7);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 6'h00, 4'd8);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 6'h00, 4'd8);
    add_row(1'b0, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b1, 6'h02, 4'd8);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h0a, 1'b0, 6'h00, 4'd7);
    // Grant and retire together through the upper half and the intra wrap
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b1, 6'h03, 4'd8);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b1, 6'h0b, 1'b1, 6'h04, 4'd7);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b1, 6'h0c, 1'b1, 6'h05, 4'd7);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b1, 6'h0d, 1'b1, 6'h06, 4'd7);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b1, 6'h0e, 1'b1, 6'h07, 4'd7);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b1, 6'h0f, 1'b1, 6'h08, 4'd7);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b1, 6'h00, 1'b1, 6'h09, 4'd7);
    add_row(1'b0, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b1, 6'h0a, 4'd7);
    add_row(1'b0, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b1, 6'h0b, 4'd6);
    // Squash at second oldest, 3 blocked cycles, new epoch starts at 0x10
    add_row(1'b0, 1'b0, 1'b1, 6'h0d, 1'b0, 6'h00, 1'b0, 6'h00, 4'd5);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 6'h00, 4'd2);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 6'h00, 4'd2);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 6'h00, 4'd2);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h10, 1'b0, 6'h00, 4'd2);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h11, 1'b0, 6'h00, 4'd3);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h12, 1'b0, 6'h00, 4'd4);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b1, 6'h13, 1'b0, 6'h00, 4'd5);
    // Squash blocks grant and retire in its own cycle
    add_row(1'b1, 1'b1, 1'b1, 6'h11, 1'b0, 6'h00, 1'b0, 6'h00, 4'd6);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b1, 6'h0c, 4'd4);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b1, 6'h0d, 4'd3);
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 6'h00, 4'd2);
    // Epoch 2 overlaps uncommitted epoch 1, stall until 0x10 commits
    add_row(1'b1, 1'b0, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 6'h00, 4'd2);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b1, 6'h10, 4'd2);
    add_row(1'b1, 1'b1, 1'b0, 6'h00, 1'b1, 6'h20, 1'b1, 6'h11, 4'd1);
    add_row(1'b0, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b1, 6'h20, 4'd1);
    add_row(1'b0, 1'b1, 1'b0, 6'h00, 1'b0, 6'h00, 1'b0, 6'h00, 4'd0);
  endtask

  // ----------------------------------------------------------------------
  // Reset, driving loop and report
  // ----------------------------------------------------------------------
  initial begin
    cur    = '0;
    rst    = 1'b1;
    active = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst    = 1'b0;
    active = 1'b1;
    // Each row is driven 1 ns after a rising edge
    for (int i = 0; i < rows.size(); i++) begin
      cur = rows[i];
      @(posedge clk);
      #1;
    end
    active = 1'b0;
    cur    = '0;
    $display("run finished: %0d rows applied, %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Bound on run length from the table size
  initial begin
    wait (table_ready);
    watchdog_ns = rows.size() * 20 + 400;
    #(watchdog_ns);
    $display("watchdog expired before the stimulus table finished");
    $display("sim failed");
    $finish;
  end

endmodule

// ==== decode_seq.f ====
common/seq_pkg.sv
seq_alloc/seq_age_cmp.sv
seq_alloc/seq_num_gen.sv
hdl/inflight_table.sv
hdl/squash_recovery_fsm.sv
hdl/decode_seq_top.sv
verif/seq_checker.sv
verif/tb_decode_seq.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode sequence-number testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_decode_seq \
  -f decode_seq.f \
  -o sim_decode_seq

output="$(./obj_dir/sim_decode_seq)"
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
  exit 0
fi
exit 1
